// ==== files.f ====
+incdir+include
rtl/mbox_pkg.sv
rtl/mbox_arb.sv
rtl/mbox_mem_ctrl.sv
rtl/mbox_regs.sv
rtl/mbox_top.sv
dv/mbox_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the mailbox testbench with Verilator and runs it from the project root
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module mbox_tb -f files.f -o mbox_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out="$(./obj_dir/mbox_sim)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
    exit 0
fi
echo "simulation reported failures"
exit 1

// ==== include/mbox_tb_model.svh ====
`ifndef MBOX_TB_MODEL_SVH
`define MBOX_TB_MODEL_SVH

// expected mailbox state, moved on only once a transfer has completed
logic [31:0] model_mem [MEM_DEPTH];
logic        model_locked;
logic [31:0] model_user;
logic [31:0] model_cmd;
logic [31:0] model_dlen;
logic        model_exec;
logic [31:0] model_status;

// registers come out of reset cleared and the lock free
function automatic void reset_model();
    model_locked = 1'b0;
    model_user   = '0;
    model_cmd    = '0;
    model_dlen   = '0;
    model_exec   = 1'b0;
    model_status = '0;
endfunction

function automatic logic in_window(input logic [15:0] addr, input logic [15:0] lo,
                                   input logic [15:0] hi);
    return (addr >= lo) && (addr <= hi);
endfunction

// expected {error, rdata} for one transfer, taken from the state before it completes
function automatic logic [32:0] expected_response(input logic [15:0] addr, input logic write,
                                                  input logic soc);
    logic [15:0]      ofs;
    logic             owner;
    logic [IDX_W-1:0] idx;
    ofs   = addr - mbox_pkg::MBOX_REG_MEM_START_ADDR;
    owner = model_locked && (model_user[0] == soc);
    // both memory windows alias onto the array through the low address bits
    idx   = addr[IDX_W-1:0];
    if (in_window(addr, mbox_pkg::MBOX_MEM_START_ADDR, mbox_pkg::MBOX_MEM_END_ADDR)) begin
        // only the lock owner gets through the checked window
        if (!owner) begin
            return {1'b1, 32'h0};
        end
        return {1'b0, write ? 32'h0 : model_mem[idx]};
    end
    if (in_window(addr, mbox_pkg::MBOX_DIR_START_ADDR, mbox_pkg::MBOX_DIR_END_ADDR)) begin
        // the direct window is the uc's alone and ignores the lock
        if (soc) begin
            return {1'b1, 32'h0};
        end
        return {1'b0, write ? 32'h0 : model_mem[idx]};
    end
    if (!in_window(addr, mbox_pkg::MBOX_REG_MEM_START_ADDR,
                   mbox_pkg::MBOX_REG_MEM_END_ADDR)) begin
        return {1'b1, 32'h0};
    end
    case (ofs)
        mbox_pkg::MBOX_LOCK_OFS:    return write ? {1'b1, 32'h0} : {1'b0, 31'h0, model_locked};
        mbox_pkg::MBOX_USER_OFS:    return write ? {1'b1, 32'h0} : {1'b0, model_user};
        mbox_pkg::MBOX_CMD_OFS:     return write ? {!owner, 32'h0} : {1'b0, model_cmd};
        mbox_pkg::MBOX_DLEN_OFS:    return write ? {!owner, 32'h0} : {1'b0, model_dlen};
        mbox_pkg::MBOX_EXECUTE_OFS: return write ? {!owner, 32'h0} : {1'b0, 31'h0, model_exec};
        // status answers the owner, so only the other side may write it during execute
        mbox_pkg::MBOX_STATUS_OFS:  return write ? {!(!owner && model_exec), 32'h0}
                                                 : {1'b0, model_status};
        default:                    return {1'b1, 32'h0};
    endcase
endfunction

// side effects of a transfer that completed without error
function automatic void apply_transfer(input logic [15:0] addr, input logic write,
                                       input logic [31:0] wdata, input logic soc);
    logic [15:0] ofs;
    ofs = addr - mbox_pkg::MBOX_REG_MEM_START_ADDR;
    if (in_window(addr, mbox_pkg::MBOX_MEM_START_ADDR, mbox_pkg::MBOX_MEM_END_ADDR) ||
        in_window(addr, mbox_pkg::MBOX_DIR_START_ADDR, mbox_pkg::MBOX_DIR_END_ADDR)) begin
        if (write) begin
            model_mem[addr[IDX_W-1:0]] = wdata;
        end
    end else if (ofs == mbox_pkg::MBOX_LOCK_OFS && !write && !model_locked) begin
        // a read of the free lock hands it to the reader
        model_locked = 1'b1;
        model_user   = {31'h0, soc};
    end else if (write) begin
        case (ofs)
            mbox_pkg::MBOX_CMD_OFS:    model_cmd = wdata;
            mbox_pkg::MBOX_DLEN_OFS:   model_dlen = wdata;
            mbox_pkg::MBOX_STATUS_OFS: model_status = wdata;
            mbox_pkg::MBOX_EXECUTE_OFS: begin
                model_exec = wdata[0];
                if (!wdata[0]) begin
                    model_locked = 1'b0;
                    model_status = '0;
                end
            end
            default: ;
        endcase
    end
endfunction

`endif

// ==== dv/mbox_tb.sv ====
`timescale 1ns/1ps

module mbox_tb;

    localparam int MEM_DEPTH = 256;
    localparam int IDX_W     = $clog2(MEM_DEPTH);
    // about 600 transfers at four cycles at worst, plus margin
    localparam int MAX_CYCLES = 4000;
    localparam int unsigned SEED = 32'h4bdcd52c;
    localparam logic UC  = 1'b0;
    localparam logic SOC = 1'b1;
    localparam logic RD  = 1'b0;
    localparam logic WR  = 1'b1;

    logic                clk = 1'b0;
    logic                rst_b;
    logic                uc_req_dv;
    mbox_pkg::mbox_req_t uc_req_data;
    logic                uc_req_hold;
    logic [31:0]         uc_rdata;
    logic                uc_error;
    logic                soc_req_dv;
    mbox_pkg::mbox_req_t soc_req_data;
    logic                soc_req_hold;
    logic [31:0]         soc_rdata;
    logic                soc_error;

    int cycle_count = 0;
    int check_count = 0;
    int error_count = 0;

    // observed and expected values waiting for the compare process
    logic [31:0] got_q [$];
    logic [31:0] exp_q [$];
    string       tag_q [$];

    `include "mbox_tb_model.svh"

    mbox_top #(
        .MBOX_MEM_DEPTH(MEM_DEPTH)
    ) DUT (
        .clk, .rst_b,
        .uc_req_dv, .uc_req_data, .uc_req_hold, .uc_rdata, .uc_error,
        .soc_req_dv, .soc_req_data, .soc_req_hold, .soc_rdata, .soc_error
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        while (got_q.size() > 0) begin
            check_value(got_q.pop_front(), exp_q.pop_front(), tag_q.pop_front());
        end
    end

    task automatic queue_compare(input logic [31:0] got, input logic [31:0] exp, input string what);
        got_q.push_back(got);
        exp_q.push_back(exp);
        tag_q.push_back(what);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the edge that completes the transfer
    task automatic uc_access(input logic [15:0] addr, input logic write, input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err, output int waits,
                             output int done_cycle);
        uc_req_data.addr    = addr;
        uc_req_data.write   = write;
        uc_req_data.wdata   = wdata;
        uc_req_data.soc_req = 1'b0;
        uc_req_dv           = 1'b1;
        waits               = 0;
        // outputs settle well before the falling edge
        @(negedge clk);
        while (uc_req_hold) begin
            waits++;
            @(negedge clk);
        end
        rdata      = uc_rdata;
        err        = uc_error;
        done_cycle = cycle_count;
        @(posedge clk);
        #1;
        uc_req_dv = 1'b0;
    endtask

    task automatic soc_access(input logic [15:0] addr, input logic write, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err, output int waits,
                              output int done_cycle);
        soc_req_data.addr    = addr;
        soc_req_data.write   = write;
        soc_req_data.wdata   = wdata;
        soc_req_data.soc_req = 1'b1;
        soc_req_dv           = 1'b1;
        waits                = 0;
        @(negedge clk);
        while (soc_req_hold) begin
            waits++;
            @(negedge clk);
        end
        rdata      = soc_rdata;
        err        = soc_error;
        done_cycle = cycle_count;
        @(posedge clk);
        #1;
        soc_req_dv = 1'b0;
    endtask

    // coll_wait is the number of cycles the request is expected to lose to the other client
    task automatic run_transfer(input logic soc, input logic [15:0] addr, input logic write,
                                input logic [31:0] wdata, input int coll_wait,
                                output int done_cycle);
        logic [31:0] rdata;
        logic        err;
        logic [32:0] resp;
        string       tag;
        int          waits;
        logic        mem_rd;
        if (soc) begin
            soc_access(addr, write, wdata, rdata, err, waits, done_cycle);
        end else begin
            uc_access(addr, write, wdata, rdata, err, waits, done_cycle);
        end
        resp = expected_response(addr, write, soc);
        tag  = $sformatf("%s %s at %h", soc ? "soc" : "uc", write ? "write" : "read", addr);
        queue_compare({31'h0, err}, {31'h0, resp[32]}, {tag, " error"});
        // read data returned alongside a successful write carries no meaning
        if (!write || resp[32]) begin
            queue_compare(rdata, resp[31:0], {tag, " rdata"});
        end
        // only an accepted memory read spends one wait state on the array
        mem_rd = !write && !resp[32] &&
                 (in_window(addr, mbox_pkg::MBOX_MEM_START_ADDR, mbox_pkg::MBOX_MEM_END_ADDR) ||
                  in_window(addr, mbox_pkg::MBOX_DIR_START_ADDR, mbox_pkg::MBOX_DIR_END_ADDR));
        queue_compare(32'(waits), 32'(coll_wait + (mem_rd ? 1 : 0)), {tag, " hold cycles"});
        if (!resp[32]) begin
            apply_transfer(addr, write, wdata, soc);
        end
    endtask

    task automatic transfer(input logic soc, input logic [15:0] addr, input logic write,
                            input logic [31:0] wdata);
        int done_cycle;
        run_transfer(soc, addr, write, wdata, 0, done_cycle);
    endtask

    function automatic logic [15:0] reg_addr(input logic [15:0] ofs);
        return mbox_pkg::MBOX_REG_MEM_START_ADDR + ofs;
    endfunction

    function automatic logic [15:0] rand_addr(input int lo, input int hi);
        int unsigned r;
        r = $urandom_range(hi, lo);
        return r[15:0];
    endfunction

    initial begin
        logic [15:0] addrs [32];
        logic [15:0] addr;
        logic [15:0] ofs_uc;
        logic [15:0] ofs_soc;
        int unsigned seed_val;
        int          done_uc;
        int          done_soc;
        rst_b        = 1'b0;
        uc_req_dv    = 1'b0;
        uc_req_data  = '0;
        soc_req_dv   = 1'b0;
        soc_req_data = '0;
        seed_val     = $urandom(SEED);
        reset_model();
        repeat (5) @(posedge clk);
        #1;
        rst_b = 1'b1;
        @(posedge clk);
        #1;

        // the array powers up unknown, so fill it through the direct window first
        for (int i = 0; i < MEM_DEPTH; i++) begin
            addr = mbox_pkg::MBOX_DIR_START_ADDR + 16'(i);
            transfer(UC, addr, WR, {addr ^ 16'h5a5a, ~addr});
        end

        // uc takes the lock and the soc finds it taken and the window closed
        transfer(UC, reg_addr(mbox_pkg::MBOX_LOCK_OFS), RD, '0);
        transfer(SOC, reg_addr(mbox_pkg::MBOX_LOCK_OFS), RD, '0);
        for (int i = 0; i < 8; i++) begin
            addr = rand_addr('h0, 'h0FFF);
            transfer(SOC, addr, WR, $urandom());
            transfer(SOC, addr, RD, '0);
            transfer(UC, addr, RD, '0);
        end

        // owner writes random words through the window and reads them back
        for (int i = 0; i < 32; i++) begin
            addrs[i] = rand_addr('h0, 'h0FFF);
            transfer(UC, addrs[i], WR, $urandom());
        end
        for (int i = 0; i < 32; i++) begin
            transfer(UC, addrs[i], RD, '0);
        end

        // direct window works for the uc only, soc accesses and holes in the map fail
        for (int i = 0; i < 16; i++) begin
            addrs[i] = rand_addr('h2000, 'h2FFF);
            transfer(UC, addrs[i], WR, $urandom());
            transfer(SOC, addrs[i], i[0] ? WR : RD, $urandom());
        end
        for (int i = 0; i < 16; i++) begin
            transfer(UC, addrs[i], RD, '0);
            transfer(UC, addrs[i] & 16'h0FFF, RD, '0);
        end
        for (int i = 0; i < 16; i++) begin
            transfer(i[0], rand_addr('h1020, 'h1FFF), WR, $urandom());
            transfer(i[0], rand_addr('h3000, 'hFFFF), RD, '0);
        end

        // command exchange with uc as owner and the soc answering in status
        transfer(UC, reg_addr(mbox_pkg::MBOX_CMD_OFS), WR, $urandom());
        transfer(UC, reg_addr(mbox_pkg::MBOX_DLEN_OFS), WR, 32'd64);
        transfer(SOC, reg_addr(mbox_pkg::MBOX_CMD_OFS), WR, $urandom());
        transfer(SOC, reg_addr(mbox_pkg::MBOX_STATUS_OFS), WR, $urandom());
        transfer(UC, reg_addr(mbox_pkg::MBOX_EXECUTE_OFS), WR, 32'd1);
        transfer(SOC, reg_addr(mbox_pkg::MBOX_EXECUTE_OFS), WR, 32'd0);
        transfer(UC, reg_addr(mbox_pkg::MBOX_STATUS_OFS), WR, $urandom());
        transfer(SOC, reg_addr(mbox_pkg::MBOX_STATUS_OFS), WR, $urandom());
        for (int i = 1; i < 6; i++) begin
            transfer(UC, reg_addr(16'(i)), RD, '0);
            transfer(SOC, reg_addr(16'(i)), RD, '0);
        end
        transfer(UC, reg_addr(mbox_pkg::MBOX_LOCK_OFS), WR, 32'd1);
        transfer(SOC, reg_addr(16'd9), RD, '0);
        transfer(UC, reg_addr(mbox_pkg::MBOX_EXECUTE_OFS), WR, 32'd0);
        transfer(SOC, reg_addr(mbox_pkg::MBOX_STATUS_OFS), RD, '0);

        // the freed lock now goes to the soc, and the window follows the owner
        transfer(SOC, reg_addr(mbox_pkg::MBOX_LOCK_OFS), RD, '0);
        transfer(SOC, reg_addr(mbox_pkg::MBOX_USER_OFS), RD, '0);
        addr = rand_addr('h0, 'h0FFF);
        transfer(SOC, addr, WR, $urandom());
        transfer(UC, addr, WR, $urandom());
        transfer(SOC, addr, RD, '0);
        transfer(UC, addr | 16'h2000, RD, '0);
        transfer(UC, addr | 16'h2000, WR, $urandom());
        transfer(SOC, addr, RD, '0);
        transfer(SOC, reg_addr(mbox_pkg::MBOX_EXECUTE_OFS), WR, 32'd0);

        // simultaneous register reads, the winner alternates starting with the uc
        for (int r = 0; r < 40; r++) begin
            ofs_uc  = rand_addr(1, 5);
            ofs_soc = rand_addr(1, 5);
            fork
                run_transfer(UC, reg_addr(ofs_uc), RD, '0, r[0] ? 1 : 0, done_uc);
                run_transfer(SOC, reg_addr(ofs_soc), RD, '0, r[0] ? 0 : 1, done_soc);
            join
            queue_compare(32'(done_uc - done_soc), r[0] ? 32'd1 : 32'hFFFF_FFFF,
                          $sformatf("uc minus soc completion cycle in round %0d", r));
        end

        repeat (2) @(posedge clk);
        #1;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== rtl/mbox_top.sv ====
`timescale 1ns/1ps

module mbox_top #(
    parameter int MBOX_MEM_DEPTH = 256
) (
    input  logic                                clk,
    input  logic                                rst_b,
    // uc client
    input  logic                                uc_req_dv,
    input  mbox_pkg::mbox_req_t                 uc_req_data,
    output logic                                uc_req_hold,
    output logic [mbox_pkg::MBOX_DATA_W-1:0]    uc_rdata,
    output logic                                uc_error,
    // soc client
    input  logic                                soc_req_dv,
    input  mbox_pkg::mbox_req_t                 soc_req_data,
    output logic                                soc_req_hold,
    output logic [mbox_pkg::MBOX_DATA_W-1:0]    soc_rdata,
    output logic                                soc_error
);

    // arbiter to memory controller
    logic                             mbox_req_dv;
    logic                             mbox_dir_req_dv;
    logic                             mbox_req_hold;
    mbox_pkg::mbox_req_t              mbox_req_data;
    logic [mbox_pkg::MBOX_DATA_W-1:0] mbox_rdata;
    logic                             mbox_error;

    // arbiter to register block
    logic                             mbox_reg_req_dv;
    logic                             mbox_reg_req_hold;
    mbox_pkg::mbox_reg_req_t          mbox_reg_req_data;
    logic [mbox_pkg::MBOX_DATA_W-1:0] mbox_reg_rdata;
    logic                             mbox_reg_error;

    // lock state that gates the memory window
    logic mbox_locked;
    logic lock_owner_soc;

    mbox_arb u_arb (
        .clk, .rst_b,
        .uc_req_dv, .uc_req_data, .uc_req_hold, .uc_rdata, .uc_error,
        .soc_req_dv, .soc_req_data, .soc_req_hold, .soc_rdata, .soc_error,
        .mbox_req_dv, .mbox_dir_req_dv, .mbox_req_hold, .mbox_req_data,
        .mbox_rdata, .mbox_error,
        .mbox_reg_req_dv, .mbox_reg_req_hold, .mbox_reg_req_data,
        .mbox_reg_rdata, .mbox_reg_error
    );

    mbox_mem_ctrl #(
        .MBOX_MEM_DEPTH(MBOX_MEM_DEPTH)
    ) u_mem_ctrl (
        .clk, .rst_b,
        .req_dv(mbox_req_dv), .dir_req_dv(mbox_dir_req_dv), .req_data(mbox_req_data),
        .req_hold(mbox_req_hold), .rdata(mbox_rdata), .error(mbox_error),
        .mbox_locked, .lock_owner_soc
    );

    mbox_regs u_regs (
        .clk, .rst_b,
        .req_dv(mbox_reg_req_dv), .req_data(mbox_reg_req_data),
        .req_hold(mbox_reg_req_hold), .rdata(mbox_reg_rdata), .error(mbox_reg_error),
        .mbox_locked, .lock_owner_soc
    );

endmodule

// ==== rtl/mbox_regs.sv ====
`timescale 1ns/1ps

module mbox_regs (
    input  logic                                clk,
    input  logic                                rst_b,
    input  logic                                req_dv,
    input  mbox_pkg::mbox_reg_req_t             req_data,
    output logic                                req_hold,
    output logic [mbox_pkg::MBOX_DATA_W-1:0]    rdata,
    output logic                                error,
    output logic                                mbox_locked,
    output logic                                lock_owner_soc
);

    localparam int W = mbox_pkg::MBOX_DATA_W;

    logic         lock_q;
    logic         execute_q;
    logic [W-1:0] user_q;
    logic [W-1:0] cmd_q;
    logic [W-1:0] dlen_q;
    logic [W-1:0] status_q;

    logic [mbox_pkg::MBOX_ADDR_W-1:0] ofs;
    logic [W-1:0]                     rd_value;
    logic                             is_owner;
    logic                             bad_access;
    logic                             take_lock;
    logic                             cmd_wr;
    logic                             dlen_wr;
    logic                             exec_wr;
    logic                             status_wr;

    assign ofs = req_data.addr - mbox_pkg::MBOX_REG_MEM_START_ADDR;

    // the user register records which client took the lock, bit 0 set for the soc
    assign is_owner = lock_q & (user_q[0] == req_data.soc_req);

    always_comb begin
        rd_value   = '0;
        bad_access = 1'b0;
        take_lock  = 1'b0;
        cmd_wr     = 1'b0;
        dlen_wr    = 1'b0;
        exec_wr    = 1'b0;
        status_wr  = 1'b0;
        if (req_dv) begin
            case (ofs)
                mbox_pkg::MBOX_LOCK_OFS: begin
                    // reading a free lock returns 0 and takes it in the same access
                    bad_access = req_data.write;
                    rd_value   = {{(W-1){1'b0}}, lock_q};
                    take_lock  = ~req_data.write & ~lock_q;
                end
                mbox_pkg::MBOX_USER_OFS: begin
                    bad_access = req_data.write;
                    rd_value   = user_q;
                end
                mbox_pkg::MBOX_CMD_OFS: begin
                    cmd_wr     = req_data.write & is_owner;
                    bad_access = req_data.write & ~is_owner;
                    rd_value   = cmd_q;
                end
                mbox_pkg::MBOX_DLEN_OFS: begin
                    dlen_wr    = req_data.write & is_owner;
                    bad_access = req_data.write & ~is_owner;
                    rd_value   = dlen_q;
                end
                mbox_pkg::MBOX_EXECUTE_OFS: begin
                    exec_wr    = req_data.write & is_owner;
                    bad_access = req_data.write & ~is_owner;
                    rd_value   = {{(W-1){1'b0}}, execute_q};
                end
                mbox_pkg::MBOX_STATUS_OFS: begin
                    // status is the receiver's answer, so only the other side writes it
                    status_wr  = req_data.write & ~is_owner & execute_q;
                    bad_access = req_data.write & ~(~is_owner & execute_q);
                    rd_value   = status_q;
                end
                default: begin
                    bad_access = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            lock_q    <= 1'b0;
            execute_q <= 1'b0;
            user_q    <= '0;
            cmd_q     <= '0;
            dlen_q    <= '0;
            status_q  <= '0;
        end else begin
            if (take_lock) begin
                lock_q <= 1'b1;
                user_q <= {{(W-1){1'b0}}, req_data.soc_req};
            end
            if (cmd_wr) begin
                cmd_q <= req_data.wdata;
            end
            if (dlen_wr) begin
                dlen_q <= req_data.wdata;
            end
            if (exec_wr) begin
                execute_q <= req_data.wdata[0];
                // clearing execute ends the exchange and frees the mailbox
                if (!req_data.wdata[0]) begin
                    lock_q   <= 1'b0;
                    status_q <= '0;
                end
            end else if (status_wr) begin
                status_q <= req_data.wdata;
            end
        end
    end

    // every register access finishes in its first cycle
    assign req_hold = 1'b0;
    assign error    = bad_access;
    assign rdata    = bad_access ? '0 : rd_value;

    assign mbox_locked    = lock_q;
    assign lock_owner_soc = user_q[0];

endmodule

// ==== rtl/mbox_mem_ctrl.sv ====
`timescale 1ns/1ps

module mbox_mem_ctrl #(
    parameter int MBOX_MEM_DEPTH = 256
) (
    input  logic                                clk,
    input  logic                                rst_b,
    input  logic                                req_dv,
    input  logic                                dir_req_dv,
    input  mbox_pkg::mbox_req_t                 req_data,
    output logic                                req_hold,
    output logic [mbox_pkg::MBOX_DATA_W-1:0]    rdata,
    output logic                                error,
    input  logic                                mbox_locked,
    input  logic                                lock_owner_soc
);

    // the depth is a power of two, so the low address bits give the modulo
    localparam int IDX_W = $clog2(MBOX_MEM_DEPTH);

    logic [mbox_pkg::MBOX_DATA_W-1:0] mem [MBOX_MEM_DEPTH];
    logic [mbox_pkg::MBOX_DATA_W-1:0] mem_q;
    logic [IDX_W-1:0]                 idx;

    logic lock_ok;
    logic access_ok;
    logic wr_en;
    logic rd_start;
    logic rd_pending;

    assign idx = req_data.addr[IDX_W-1:0];

    // the window is open only to the client that currently holds the lock
    assign lock_ok = mbox_locked & (lock_owner_soc == req_data.soc_req);

    // direct window accesses are uc only and bypass the lock entirely
    assign access_ok = dir_req_dv | (req_dv & lock_ok);

    // writes land in the first cycle and never wait
    assign wr_en = access_ok & req_data.write;

    // a read spends its first cycle fetching from the array
    assign rd_start = access_ok & ~req_data.write & ~rd_pending;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[idx] <= req_data.wdata;
        end
        if (rd_start) begin
            mem_q <= mem[idx];
        end
    end

    // set for exactly the one cycle in which the fetched word is handed back
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rd_pending <= 1'b0;
        end else begin
            rd_pending <= rd_start;
        end
    end

    assign req_hold = rd_start;

    // a refused window access completes immediately, nothing written and rdata zero
    assign error = req_dv & ~lock_ok;
    assign rdata = rd_pending ? mem_q : '0;

endmodule

// ==== rtl/mbox_arb.sv ====
`timescale 1ns/1ps

module mbox_arb (
    input  logic                                clk,
    input  logic                                rst_b,
    // uc client
    input  logic                                uc_req_dv,
    input  mbox_pkg::mbox_req_t                 uc_req_data,
    output logic                                uc_req_hold,
    output logic [mbox_pkg::MBOX_DATA_W-1:0]    uc_rdata,
    output logic                                uc_error,
    // soc client
    input  logic                                soc_req_dv,
    input  mbox_pkg::mbox_req_t                 soc_req_data,
    output logic                                soc_req_hold,
    output logic [mbox_pkg::MBOX_DATA_W-1:0]    soc_rdata,
    output logic                                soc_error,
    // memory controller target
    output logic                                mbox_req_dv,
    output logic                                mbox_dir_req_dv,
    input  logic                                mbox_req_hold,
    output mbox_pkg::mbox_req_t                 mbox_req_data,
    input  logic [mbox_pkg::MBOX_DATA_W-1:0]    mbox_rdata,
    input  logic                                mbox_error,
    // register block target
    output logic                                mbox_reg_req_dv,
    input  logic                                mbox_reg_req_hold,
    output mbox_pkg::mbox_reg_req_t             mbox_reg_req_data,
    input  logic [mbox_pkg::MBOX_DATA_W-1:0]    mbox_reg_rdata,
    input  logic                                mbox_reg_error
);

    localparam int W = mbox_pkg::MBOX_DATA_W;

    // window decode per client, already qualified with the client's dv
    logic uc_mem_req;
    logic uc_dir_req;
    logic uc_any_mem;
    logic uc_reg_req;
    logic soc_mem_req;
    logic soc_reg_req;

    logic mem_collision;
    logic reg_collision;
    logic soc_has_priority;
    logic toggle_priority;

    // a target that held last cycle stays with the same client until it completes
    logic mem_held_q;
    logic mem_held_soc_q;
    logic reg_held_q;
    logic reg_held_soc_q;
    logic mem_soc_sel;
    logic reg_soc_sel;

    // the client that is forwarded to each target this cycle
    logic uc_mem_win;
    logic soc_mem_win;
    logic uc_reg_win;
    logic soc_reg_win;

    always_comb begin
        uc_mem_req  = uc_req_dv & (uc_req_data.addr inside
                      {[mbox_pkg::MBOX_MEM_START_ADDR:mbox_pkg::MBOX_MEM_END_ADDR]});
        uc_dir_req  = uc_req_dv & (uc_req_data.addr inside
                      {[mbox_pkg::MBOX_DIR_START_ADDR:mbox_pkg::MBOX_DIR_END_ADDR]});
        uc_reg_req  = uc_req_dv & (uc_req_data.addr inside
                      {[mbox_pkg::MBOX_REG_MEM_START_ADDR:mbox_pkg::MBOX_REG_MEM_END_ADDR]});
        // the soc never decodes the direct window, so it falls through to an error
        soc_mem_req = soc_req_dv & (soc_req_data.addr inside
                      {[mbox_pkg::MBOX_MEM_START_ADDR:mbox_pkg::MBOX_MEM_END_ADDR]});
        soc_reg_req = soc_req_dv & (soc_req_data.addr inside
                      {[mbox_pkg::MBOX_REG_MEM_START_ADDR:mbox_pkg::MBOX_REG_MEM_END_ADDR]});
    end

    // both memory windows land on the same controller, so they collide together
    assign uc_any_mem    = uc_mem_req | uc_dir_req;
    assign mem_collision = uc_any_mem & soc_mem_req;
    assign reg_collision = uc_reg_req & soc_reg_req;

    // a held transfer keeps its grant, otherwise the least recently granted client wins
    assign mem_soc_sel = mem_held_q ? mem_held_soc_q : soc_has_priority;
    assign reg_soc_sel = reg_held_q ? reg_held_soc_q : soc_has_priority;

    assign uc_mem_win  = uc_any_mem  & ~(mem_collision & mem_soc_sel);
    assign soc_mem_win = soc_mem_req & ~(mem_collision & ~mem_soc_sel);
    assign uc_reg_win  = uc_reg_req  & ~(reg_collision & reg_soc_sel);
    assign soc_reg_win = soc_reg_req & ~(reg_collision & ~reg_soc_sel);

    // priority moves on only once the colliding transfer actually completes
    assign toggle_priority = (mem_collision & ~mbox_req_hold) |
                             (reg_collision & ~mbox_reg_req_hold);

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            soc_has_priority <= 1'b0;
            mem_held_q       <= 1'b0;
            mem_held_soc_q   <= 1'b0;
            reg_held_q       <= 1'b0;
            reg_held_soc_q   <= 1'b0;
        end else begin
            if (toggle_priority) begin
                soc_has_priority <= ~soc_has_priority;
            end
            mem_held_q     <= (mbox_req_dv | mbox_dir_req_dv) & mbox_req_hold;
            mem_held_soc_q <= soc_mem_win;
            reg_held_q     <= mbox_reg_req_dv & mbox_reg_req_hold;
            reg_held_soc_q <= soc_reg_win;
        end
    end

    // only the granted client drives the target strobes and the request
    assign mbox_req_dv     = (uc_mem_win & uc_mem_req) | soc_mem_win;
    assign mbox_dir_req_dv = uc_mem_win & uc_dir_req;
    assign mbox_req_data   = soc_mem_win ? soc_req_data : uc_req_data;
    assign mbox_reg_req_dv = uc_reg_win | soc_reg_win;

    always_comb begin
        mbox_reg_req_data.addr    = soc_reg_win ? soc_req_data.addr    : uc_req_data.addr;
        mbox_reg_req_data.write   = soc_reg_win ? soc_req_data.write   : uc_req_data.write;
        mbox_reg_req_data.wdata   = soc_reg_win ? soc_req_data.wdata   : uc_req_data.wdata;
        mbox_reg_req_data.soc_req = soc_reg_win ? soc_req_data.soc_req : uc_req_data.soc_req;
    end

    // return paths are AND/OR muxes, the grants of one client never overlap
    assign uc_rdata  = ({W{uc_mem_win}} & mbox_rdata) | ({W{uc_reg_win}} & mbox_reg_rdata);
    assign soc_rdata = ({W{soc_mem_win}} & mbox_rdata) | ({W{soc_reg_win}} & mbox_reg_rdata);

    // a losing client is held, a winning one sees the target's own hold
    assign uc_req_hold  = (uc_any_mem & ~uc_mem_win) | (uc_reg_req & ~uc_reg_win) |
                          (uc_mem_win & mbox_req_hold) | (uc_reg_win & mbox_reg_req_hold);
    assign soc_req_hold = (soc_mem_req & ~soc_mem_win) | (soc_reg_req & ~soc_reg_win) |
                          (soc_mem_win & mbox_req_hold) | (soc_reg_win & mbox_reg_req_hold);

    // unmapped addresses complete at once with an error and no target access
    assign uc_error  = (uc_mem_win & mbox_error) | (uc_reg_win & mbox_reg_error) |
                       (uc_req_dv & ~(uc_any_mem | uc_reg_req));
    assign soc_error = (soc_mem_win & mbox_error) | (soc_reg_win & mbox_reg_error) |
                       (soc_req_dv & ~(soc_mem_req | soc_reg_req));

endmodule

// ==== rtl/mbox_pkg.sv ====
package mbox_pkg;

    // both clients and every target move one word per transfer
    localparam int MBOX_DATA_W = 32;
    localparam int MBOX_ADDR_W = 16;

    // lock-checked memory window, reachable by whichever client owns the lock
    localparam logic [MBOX_ADDR_W-1:0] MBOX_MEM_START_ADDR = 16'h0000;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_MEM_END_ADDR   = 16'h0FFF;

    // register window, 32 words of which only the first six are decoded
    localparam logic [MBOX_ADDR_W-1:0] MBOX_REG_MEM_START_ADDR = 16'h1000;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_REG_MEM_END_ADDR   = 16'h101F;

    // direct window onto the same array, uc only and never lock-checked
    localparam logic [MBOX_ADDR_W-1:0] MBOX_DIR_START_ADDR = 16'h2000;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_DIR_END_ADDR   = 16'h2FFF;

    // word offsets of the registers, relative to the start of the register window
    localparam logic [MBOX_ADDR_W-1:0] MBOX_LOCK_OFS    = 16'd0;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_USER_OFS    = 16'd1;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_CMD_OFS     = 16'd2;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_DLEN_OFS    = 16'd3;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_EXECUTE_OFS = 16'd4;
    localparam logic [MBOX_ADDR_W-1:0] MBOX_STATUS_OFS  = 16'd5;

    // request as issued by a client and forwarded to the memory controller
    // soc_req is 1 when the request came in on the soc port
    typedef struct packed {
        logic [MBOX_ADDR_W-1:0] addr;
        logic                   write;
        logic [MBOX_DATA_W-1:0] wdata;
        logic                   soc_req;
    } mbox_req_t;

    // request as seen by the register block, same fields as the client request
    typedef struct packed {
        logic [MBOX_ADDR_W-1:0] addr;
        logic                   write;
        logic [MBOX_DATA_W-1:0] wdata;
        logic                   soc_req;
    } mbox_reg_req_t;

endpackage
